// ==== mem_pkg.sv ====
// Shared line geometry, opcode and write-size types for the main memory.
// Imported by the decoder, the banks, the read return and the request interface.
package mem_pkg;

   // Line geometry
   // A line is 32 byte lanes, addressed by the low column bits
   localparam int line_bytes = 32;
   localparam int line_bits  = line_bytes * 8;
   localparam int col_bits   = 5;

   // Request opcode
   typedef enum logic {
      mem_read  = 1'b0,
      mem_write = 1'b1
   } mem_op_e;

   // Write size
   // Values 1, 2 and 4 give the byte count of the span.
   // Zero writes the whole line, every other code is illegal.
   typedef enum logic [2:0] {
      size_line = 3'd0,
      size_byte = 3'd1,
      size_half = 3'd2,
      size_word = 3'd4
   } mem_size_e;

endpackage

// ==== mem_req_if.sv ====
// Decoded request as seen by every bank and by the read return stage.
// Driven by the decoder one cycle after the request strobe.
`timescale 1ns/1ps

interface mem_req_if #(
   parameter int bank_bits = 3,
   parameter int row_bits  = 7
);
   import mem_pkg::*;

   logic                    valid;
   logic                    write;
   // One-hot bank select
   logic [2**bank_bits-1:0] bank_sel;
   logic [row_bits-1:0]     row;
   // One bit per byte lane, all zero on reads
   logic [line_bytes-1:0]   byte_mask;
   logic [line_bits-1:0]    wdata;

   modport decoder (output valid, write, bank_sel, row, byte_mask, wdata);
   modport bank    (input valid, write, bank_sel, row, byte_mask, wdata);
   // Read return only needs to know which bank answers and whether it is a read
   modport ret     (input valid, write, bank_sel);

endinterface

// ==== byte_sram.sv ====
// One byte-wide synchronous SRAM lane, 2**row_bits deep.
// Write and registered read both happen on the rising clock edge.
`timescale 1ns/1ps

module byte_sram #(
   parameter int row_bits = 7
) (
   input  logic                clk,
   input  logic                en,
   input  logic                we,
   input  logic [row_bits-1:0] row,
   input  logic [7:0]          din,
   output logic [7:0]          dout
);

   logic [7:0] mem [2**row_bits];

   // Write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[row] <= din;
      end
   end

   // Read port, holds its value while the lane is idle
   // On a write cycle this returns the old byte, which nobody consumes
   always_ff @(posedge clk) begin
      if (en) begin
         dout <= mem[row];
      end
   end

endmodule

// ==== mem_bank.sv ====
// One memory bank built from 32 byte lanes sharing a row address.
// Responds only when the decoded request selects this bank.
`timescale 1ns/1ps

module mem_bank #(
   parameter int bank_bits = 3,
   parameter int row_bits  = 7
) (
   input  logic                         clk,
   mem_req_if.bank                      bus,
   input  logic [bank_bits-1:0]         bank_id,
   output logic [mem_pkg::line_bits-1:0] line
);
   import mem_pkg::*;

   logic sel;
   logic wr;

   // Bank is active on any valid request that targets it
   assign sel = bus.valid && bus.bank_sel[bank_id];
   assign wr  = sel && bus.write;

   // Byte lanes
   for (genvar i = 0; i < line_bytes; i++) begin : g_lane
      byte_sram #(
         .row_bits(row_bits)
      ) sram_i (
         .clk (clk),
         .en  (sel),
         .we  (wr && bus.byte_mask[i]),
         .row (bus.row),
         .din (bus.wdata[8*i +: 8]),
         .dout(line[8*i +: 8])
      );
   end

   // Mask comes from the decoder, a selected write must touch at least one lane
   a_write_mask: assert property (
      @(posedge clk) wr |-> (bus.byte_mask != '0)
   ) else $error("bank %0d written with an empty byte mask", bank_id);

endmodule

// ==== mem_req_decode.sv ====
// Request stage: splits the address, builds the byte write mask and
// registers the decoded request onto the bank interface.
`timescale 1ns/1ps

module mem_req_decode #(
   parameter int bank_bits = 3,
   parameter int row_bits  = 7
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          req,
   input  mem_pkg::mem_op_e                              op,
   input  logic [bank_bits+row_bits+mem_pkg::col_bits-1:0] addr,
   input  mem_pkg::mem_size_e                            size,
   input  logic [mem_pkg::line_bits-1:0]                 wdata,
   mem_req_if.decoder                                    bus
);
   import mem_pkg::*;

   logic [bank_bits-1:0]    bank;
   logic [row_bits-1:0]     row;
   logic [col_bits-1:0]     col;
   logic [2**bank_bits-1:0] sel;
   logic [line_bytes-1:0]   span;
   logic [line_bytes-1:0]   mask;

   // Address fields, bank on top and byte column at the bottom
   assign {bank, row, col} = addr;

   // One-hot bank select
   always_comb begin
      sel       = '0;
      sel[bank] = 1'b1;
   end

   // Span of ones starting at bit 0, one bit per byte written
   always_comb begin
      case (size)
         size_byte: span = line_bytes'(4'h1);
         size_half: span = line_bytes'(4'h3);
         size_word: span = line_bytes'(4'hf);
         default:   span = '1;
      endcase
   end

   // Shifting up to the column clips at byte 31, no wrap
   always_comb begin
      if (op == mem_read) begin
         mask = '0;
      end else if (size == size_line) begin
         mask = '1;
      end else begin
         mask = span << col;
      end
   end

   // Control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus.valid <= 1'b0;
         bus.write <= 1'b0;
      end else begin
         bus.valid <= req;
         bus.write <= req && (op == mem_write);
      end
   end

   // Payload, only captured with a request
   always_ff @(posedge clk) begin
      if (req) begin
         bus.bank_sel  <= sel;
         bus.row       <= row;
         bus.byte_mask <= mask;
         bus.wdata     <= wdata;
      end
   end

   a_size_legal: assert property (
      @(posedge clk) disable iff (!rst_n)
      req |-> (size inside {size_line, size_byte, size_half, size_word})
   ) else $error("illegal write size %0d", size);

   // Banks rely on exactly one of them answering
   a_sel_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.valid |-> $onehot(bus.bank_sel)
   ) else $error("bank select not one-hot: %b", bus.bank_sel);

endmodule

// ==== mem_read_return.sv ====
// Read return stage: picks the answering bank's line and presents it
// on rdata with a one-cycle rvalid, three edges after the request.
`timescale 1ns/1ps

module mem_read_return #(
   parameter int bank_bits = 3
) (
   input  logic                          clk,
   input  logic                          rst_n,
   mem_req_if.ret                        bus,
   input  logic [mem_pkg::line_bits-1:0] lines [2**bank_bits],
   output logic [mem_pkg::line_bits-1:0] rdata,
   output logic                          rvalid
);
   import mem_pkg::*;

   logic [bank_bits-1:0] idx;
   logic [bank_bits-1:0] bank_idx;
   logic                 rd_pend;

   // Encode the one-hot select back to a bank number
   always_comb begin
      idx = '0;
      for (int b = 0; b < 2**bank_bits; b++) begin
         if (bus.bank_sel[b]) begin
            idx = bank_bits'(b);
         end
      end
   end

   // Tracks the request while the banks read the SRAM
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= bus.valid && !bus.write;
      end
   end

   always_ff @(posedge clk) begin
      if (bus.valid) begin
         bank_idx <= idx;
      end
   end

   // Bank outputs are settled here, one edge after the SRAM read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rvalid <= 1'b0;
         rdata  <= '0;
      end else begin
         rvalid <= rd_pend;
         if (rd_pend) begin
            rdata <= lines[bank_idx];
         end
      end
   end

   // Writes travel the same pipeline but must never show up as a response
   a_no_write_resp: assert property (
      @(posedge clk) disable iff (!rst_n)
      (bus.valid && bus.write) |-> ##2 !rvalid
   ) else $error("rvalid raised for a write request");

endmodule

// ==== main_memory.sv ====
// Line-organized main memory top level with separate write and read data.
// One request per cycle on req, read data returns three edges later.
`timescale 1ns/1ps

module main_memory #(
   parameter int bank_bits = 3,
   parameter int row_bits  = 7
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          req,
   input  mem_pkg::mem_op_e                              op,
   input  logic [bank_bits+row_bits+mem_pkg::col_bits-1:0] addr,
   input  mem_pkg::mem_size_e                            size,
   input  logic [mem_pkg::line_bits-1:0]                 wdata,
   output logic [mem_pkg::line_bits-1:0]                 rdata,
   output logic                                          rvalid
);
   import mem_pkg::*;

   // One line output per bank
   logic [line_bits-1:0] lines [2**bank_bits];

   mem_req_if #(
      .bank_bits(bank_bits),
      .row_bits (row_bits)
   ) req_bus ();

   mem_req_decode #(
      .bank_bits(bank_bits),
      .row_bits (row_bits)
   ) decode_i (
      .clk  (clk),
      .rst_n(rst_n),
      .req  (req),
      .op   (op),
      .addr (addr),
      .size (size),
      .wdata(wdata),
      .bus  (req_bus.decoder)
   );

   for (genvar b = 0; b < 2**bank_bits; b++) begin : g_bank
      mem_bank #(
         .bank_bits(bank_bits),
         .row_bits (row_bits)
      ) bank_i (
         .clk    (clk),
         .bus    (req_bus.bank),
         .bank_id(bank_bits'(b)),
         .line   (lines[b])
      );
   end

   mem_read_return #(
      .bank_bits(bank_bits)
   ) ret_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (req_bus.ret),
      .lines (lines),
      .rdata (rdata),
      .rvalid(rvalid)
   );

endmodule

// ==== tb_main_memory.sv ====
// Testbench for the main memory that replays the request trace from main_memory_trace.txt
// and checks every returned read line against the expected line in the trace.
`timescale 1ns/1ps

module tb_main_memory #(
   parameter int bank_bits = 3,
   parameter int row_bits  = 7
);
   import mem_pkg::*;

   localparam int addr_bits = bank_bits + row_bits + col_bits;

   logic                 clk;
   logic                 rst_n;
   logic                 req;
   mem_op_e              op;
   logic [addr_bits-1:0] addr;
   mem_size_e            size;
   logic [line_bits-1:0] wdata;
   logic [line_bits-1:0] rdata;
   logic                 rvalid;

   // Trace entries in request order
   byte                  op_tr[$];
   logic [addr_bits-1:0] addr_tr[$];
   logic [2:0]           size_tr[$];
   logic [line_bits-1:0] wdata_tr[$];
   logic [line_bits-1:0] exp_tr[$];
   string                name_tr[$];

   // Reads in flight with the oldest at the front
   logic [line_bits-1:0] exp_q[$];
   string                name_q[$];

   int errors       = 0;
   int stray_count  = 0;
   int read_count   = 0;
   int rvalid_count = 0;
   bit trace_loaded = 1'b0;

   main_memory #(
      .bank_bits(bank_bits),
      .row_bits (row_bits)
   ) main_memory_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .op    (op),
      .addr  (addr),
      .size  (size),
      .wdata (wdata),
      .rdata (rdata),
      .rvalid(rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic load_trace();
      int                   fd;
      int                   rc;
      string                tok;
      string                rest;
      string                nm;
      logic [addr_bits-1:0] a;
      logic [2:0]           s;
      logic [line_bits-1:0] w;
      logic [line_bits-1:0] e;
      fd = $fopen("main_memory_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open main_memory_trace.txt");
         errors++;
      end else begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
               rc = $fgets(rest, fd);
            end else begin
               rc = $fscanf(fd, "%h %d %h %h %s", a, s, w, e, nm);
               if (rc != 5 || !(tok inside {"w", "r", "i"})) begin
                  $display("Malformed trace entry starting with %s", tok);
                  errors++;
               end else begin
                  op_tr.push_back(tok.getc(0));
                  addr_tr.push_back(a);
                  size_tr.push_back(s);
                  wdata_tr.push_back(w);
                  exp_tr.push_back(e);
                  name_tr.push_back(nm);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Outputs are sampled on the falling edge half a cycle after they change
   task automatic check_response();
      logic [line_bits-1:0] exp_line;
      string                exp_name;
      if (rvalid === 1'b1) begin
         rvalid_count++;
         if (exp_q.size() == 0) begin
            $display("rvalid pulse arrived with no read outstanding");
            stray_count++;
         end else begin
            exp_line = exp_q.pop_front();
            exp_name = name_q.pop_front();
            assert (rdata === exp_line) else begin
               $display("** Error: %s expected %h actual %h", exp_name, exp_line, rdata);
               errors++;
            end
         end
      end
   endtask

   task automatic drive_request(int i);
      req   = 1'b0;
      op    = mem_read;
      addr  = addr_tr[i];
      size  = size_line;
      wdata = '0;
      case (op_tr[i])
         "w": begin
            req   = 1'b1;
            op    = mem_write;
            size  = mem_size_e'(size_tr[i]);
            wdata = wdata_tr[i];
         end
         "r": begin
            req = 1'b1;
            exp_q.push_back(exp_tr[i]);
            name_q.push_back(name_tr[i]);
            read_count++;
         end
         default: ;
      endcase
   endtask

   task automatic next_cycle();
      @(negedge clk);
      check_response();
   endtask

   initial begin
      rst_n = 1'b0;
      req   = 1'b0;
      op    = mem_read;
      addr  = '0;
      size  = size_line;
      wdata = '0;
      load_trace();
      trace_loaded = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < op_tr.size(); i++) begin
         next_cycle();
         drive_request(i);
      end
      next_cycle();
      req = 1'b0;
      // Drain the pipeline, then a few more cycles to catch late pulses
      while (exp_q.size() != 0) begin
         next_cycle();
      end
      repeat (4) next_cycle();
      // Writes must not produce any response
      assert (rvalid_count == read_count) else begin
         $display("Saw %0d rvalid pulses for %0d reads in the trace", rvalid_count, read_count);
         errors++;
      end
      $display("errors: %0d, stray rvalid: %0d, reads: %0d, rvalid pulses: %0d",
               errors, stray_count, read_count, rvalid_count);
      if (errors == 0 && stray_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog sized from reset plus trace length with margin
   initial begin
      wait (trace_loaded);
      repeat (16 + op_tr.size() + 50) @(posedge clk);
      $display("Watchdog expired before the trace finished, %0d reads still outstanding",
               exp_q.size());
      $display("errors: %0d, stray rvalid: %0d, reads: %0d, rvalid pulses: %0d",
               errors, stray_count, read_count, rvalid_count);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== main_memory_trace.txt ====
# op (w write, r read, i idle) addr(hex) size(0 line, 1, 2, 4) wdata(hex) expected(hex) name
# expected is used on reads only, wdata on writes only
w 0000 0 0302010003020100030201000302010003020100030201000302010003020100 0 full_b0_r0
w 1000 0 1312111013121110131211101312111013121110131211101312111013121110 0 full_b1_r0
w 2000 0 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100 0 full_b2_r0
w 3000 0 3332313033323130333231303332313033323130333231303332313033323130 0 full_b3_r0
w 4000 0 4342414043424140434241404342414043424140434241404342414043424140 0 full_b4_r0
w 5000 0 5352515053525150535251505352515053525150535251505352515053525150 0 full_b5_r0
w 6000 0 6362616063626160636261606362616063626160636261606362616063626160 0 full_b6_r0
w 7000 0 7372717073727170737271707372717073727170737271707372717073727170 0 full_b7_r0
w 0fe0 0 f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0 0 full_b0_r127
w 1fe0 0 f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1 0 full_b1_r127
w 2fe0 0 f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2 0 full_b2_r127
w 3fe0 0 f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3 0 full_b3_r127
w 4fe0 0 f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4 0 full_b4_r127
w 5fe0 0 f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5 0 full_b5_r127
w 6fe0 0 f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6 0 full_b6_r127
w 7fe0 0 f7e7d7c7f7e7d7c7f7e7d7c7f7e7d7c7f7e7d7c7f7e7d7c7f7e7d7c7f7e7d7c7 0 full_b7_r127
w 2003 1 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0efeeedecebeae9e8e7e6e5e4e3e2e1e0 0 byte_col3
r 2000 0 0 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a090807060504e3020100 b2b_byte_col3
w 2008 2 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0efeeedecebeae9e8e7e6e5e4e3e2e1e0 0 half_col8
w 2010 4 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0efeeedecebeae9e8e7e6e5e4e3e2e1e0 0 word_col16
w 201e 4 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0efeeedecebeae9e8e7e6e5e4e3e2e1e0 0 word_col30_clip
i 0000 0 0 0 idle_gap
r 0000 0 0 0302010003020100030201000302010003020100030201000302010003020100 read_b0_r0
r 1000 0 0 1312111013121110131211101312111013121110131211101312111013121110 read_b1_r0
r 2000 0 0 fffe1d1c1b1a191817161514f3f2f1f00f0e0d0c0b0ae9e807060504e3020100 read_b2_r0_spans
r 3000 0 0 3332313033323130333231303332313033323130333231303332313033323130 read_b3_r0
r 4000 0 0 4342414043424140434241404342414043424140434241404342414043424140 read_b4_r0
r 5000 0 0 5352515053525150535251505352515053525150535251505352515053525150 read_b5_r0
r 6000 0 0 6362616063626160636261606362616063626160636261606362616063626160 read_b6_r0
r 7000 0 0 7372717073727170737271707372717073727170737271707372717073727170 read_b7_r0
w 7fe0 0 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 0 rewrite_b7_r127
r 7fe0 0 0 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 b2b_rewrite_b7
r 0fe0 0 0 f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0f0e0d0c0 read_b0_r127
r 1fe0 0 0 f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1f1e1d1c1 read_b1_r127
r 2fe0 0 0 f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2f2e2d2c2 read_b2_r127
r 3fe0 0 0 f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3f3e3d3c3 read_b3_r127
r 4fe0 0 0 f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4f4e4d4c4 read_b4_r127
r 5fe0 0 0 f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5f5e5d5c5 read_b5_r127
r 6fe0 0 0 f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6f6e6d6c6 read_b6_r127
r 7fe0 0 0 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 read_b7_r127

// ==== project.f ====
mem_pkg.sv
mem_req_if.sv
byte_sram.sv
mem_bank.sv
mem_req_decode.sv
mem_read_return.sv
main_memory.sv
tb_main_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The run counts as passed only when the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_main_memory -f project.f \
   -o tb_main_memory \
   && ./obj_dir/tb_main_memory | tee /dev/stderr | grep -qx "sim passed" \
   || exit 1
